//--- flist.f
+incdir+source
source/ooo_pkg.sv
source/dispatch_decode.sv
source/issue_queue.sv
source/alu_execute.sv
source/result_regfile.sv
source/issue_core_top.sv
dv/tb_clock_gen.sv
dv/issue_core_tb.sv

//--- Bender.yml
package:
  name: issue_core

sources:
  - include_dirs:
      - source
    files:
      - source/ooo_pkg.sv
      - source/dispatch_decode.sv
      - source/issue_queue.sv
      - source/alu_execute.sv
      - source/result_regfile.sv
      - source/issue_core_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_clock_gen.sv
      - dv/issue_core_tb.sv

//--- dv/issue_core_tb.sv
`timescale 1ns/1ns

`include "ooo_macros.svh"

module issue_core_tb
    import ooo_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int NUM_LI         = 8;
    localparam int NUM_ALU        = 120;
    localparam int NUM_CHAIN      = 100;
    localparam int NUM_WAW        = 60;
    localparam int NUM_BURST      = 111;
    // one extra for the zero check after reset
    localparam int NUM_INSTR      = 1 + NUM_LI + NUM_ALU + NUM_CHAIN + NUM_WAW + NUM_BURST;
    localparam int DRAIN_CYCLES   = 200;
    localparam int TIMEOUT_CYCLES = 10 * NUM_INSTR + DRAIN_CYCLES;
    localparam int EXP_DEPTH      = 16;

    logic                          clk;
    logic                          rst_n;
    logic                          instr_valid;
    logic [`OOO_INSTR_W-1:0]       instr;
    logic                          stall;
    logic                          res_valid;
    logic [`OOO_TAG_W-1:0]         res_tag;
    logic [`OOO_DATA_W-1:0]        res_data;

    logic [`OOO_DATA_W-1:0] model_regs [`OOO_REG_NUM];
    logic [`OOO_DATA_W-1:0] exp_buf [`OOO_REG_NUM][EXP_DEPTH];
    int                     exp_wr [`OOO_REG_NUM];
    int                     exp_rd [`OOO_REG_NUM];
    int                     accepted_cnt;
    int                     result_cnt;
    int                     value_errs;
    int                     other_errs;
    int                     cycle_cnt;
    logic                   stall_seen;
    logic [31:0]            lfsr_state;
    string                  test_name;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_core_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .res_valid   (res_valid),
        .res_tag     (res_tag),
        .res_data    (res_data)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [15:0] make_instr(input logic [2:0] op, input logic [2:0] d,
                                               input logic [2:0] s1, input logic [2:0] s2);
        return {op, d, s1, s2, 4'h0};
    endfunction

    // in-order reference over the model's own registers
    task automatic model_exec(input logic [15:0] w);
        logic [2:0]  d;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        d = w[12:10];
        a = model_regs[w[9:7]];
        b = model_regs[w[6:4]];
        case (alu_op_e'(w[15:13]))
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[3:0];
            OP_SRL:  r = a >> b[3:0];
            default: r = {10'h000, w[9:4]};
        endcase
        model_regs[d] = r;
        exp_buf[d][exp_wr[d] % EXP_DEPTH] = r;
        exp_wr[d]++;
        accepted_cnt++;
    endtask

    // hold the word until stall drops, acceptance at the next rising edge
    task automatic send_instr(input logic [15:0] w);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = w;
        #(CLK_PERIOD / 4);
        while (stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        model_exec(w);
    endtask

    task automatic wait_drain();
        @(negedge clk);
        instr_valid = 1'b0;
        while (result_cnt < accepted_cnt) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic require_stall();
        assert (stall_seen) else begin
            other_errs++;
            $display("stall never went high during %s", test_name);
        end
    endtask

    task automatic send_random(input logic no_li, input logic [2:0] d, input logic [2:0] s1);
        logic [31:0] v;
        rand_bits(6, v);
        if (no_li && v[5:3] == OP_LI) begin
            v[5:3] = OP_ADD;
        end
        send_instr(make_instr(v[5:3], d, s1, v[2:0]));
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin : check_results
        logic [15:0] exp_val;
        if (rst_n && res_valid) begin
            result_cnt++;
            assert (exp_rd[res_tag] != exp_wr[res_tag]) else begin
                other_errs++;
                $display("result on r%0d with no instruction pending", res_tag);
            end
            if (exp_rd[res_tag] != exp_wr[res_tag]) begin
                exp_val = exp_buf[res_tag][exp_rd[res_tag] % EXP_DEPTH];
                exp_rd[res_tag]++;
                assert (res_data === exp_val) else begin
                    value_errs++;
                    $display("error %s: r%0d expected %h actual %h",
                             test_name, res_tag, exp_val, res_data);
                end
            end
        end
    end

    initial begin : main_seq
        logic [31:0] v;
        logic [2:0]  prev;
        instr_valid  = 1'b0;
        instr        = '0;
        accepted_cnt = 0;
        result_cnt   = 0;
        value_errs   = 0;
        other_errs   = 0;
        cycle_cnt    = 0;
        lfsr_state   = 32'hebca_5a62;
        for (int r = 0; r < `OOO_REG_NUM; r++) begin
            model_regs[r] = '0;
            exp_wr[r]     = 0;
            exp_rd[r]     = 0;
        end
        wait (rst_n === 1'b1);

        // a pending word must not stall the empty core
        test_name = "reset_zero";
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = make_instr(OP_ADD, 3'd2, 3'd0, 3'd1);
        #(CLK_PERIOD / 4);
        assert (stall === 1'b0 && res_valid === 1'b0) else begin
            other_errs++;
            $display("stall or res_valid not low after reset");
        end
        model_exec(instr);
        wait_drain();

        test_name = "li_independent";
        for (int i = 0; i < NUM_LI; i++) begin
            rand_bits(6, v);
            send_instr({OP_LI, 3'(i), v[5:0], 4'h0});
        end
        wait_drain();

        // drained before each one, so both sources are ready
        test_name = "alu_ready";
        for (int i = 0; i < NUM_ALU; i++) begin
            rand_bits(6, v);
            send_random(1'b0, v[5:3], v[2:0]);
            wait_drain();
        end

        test_name = "dep_chain";
        rand_bits(3, v);
        prev = v[2:0];
        for (int i = 0; i < NUM_CHAIN; i++) begin
            rand_bits(3, v);
            send_random(1'b1, v[2:0], prev);
            prev = v[2:0];
        end
        wait_drain();

        test_name  = "waw_same_reg";
        stall_seen = 1'b0;
        for (int i = 0; i < NUM_WAW; i++) begin
            rand_bits(4, v);
            send_random(1'b0, {2'b00, v[3]}, v[2:0]);
        end
        wait_drain();
        require_stall();

        // chain on r7 mixed with independent work on r0..r6
        test_name  = "burst_fill";
        stall_seen = 1'b0;
        for (int i = 0; i < NUM_BURST; i++) begin
            rand_bits(4, v);
            if (v[3]) begin
                send_random(1'b1, 3'd7, 3'd7);
            end else begin
                send_random(1'b0, (v[2:0] == 3'd7) ? 3'd0 : v[2:0], v[2:0]);
            end
        end
        wait_drain();
        require_stall();

        assert (result_cnt == accepted_cnt) else begin
            other_errs++;
            $display("%0d results seen for %0d accepted instructions",
                     result_cnt, accepted_cnt);
        end
        for (int r = 0; r < `OOO_REG_NUM; r++) begin
            assert (exp_rd[r] == exp_wr[r]) else begin
                other_errs++;
                $display("r%0d still has %0d results missing", r, exp_wr[r] - exp_rd[r]);
            end
        end

        $display("errors: value %0d, other %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // low for the first two cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- source/issue_core_top.sv
`timescale 1ns/1ns

`include "ooo_macros.svh"

module issue_core_top
    import ooo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [`OOO_INSTR_W-1:0] instr,
    output logic                   stall,
    output logic                   res_valid,
    output logic [`OOO_TAG_W-1:0]  res_tag,
    output logic [`OOO_DATA_W-1:0] res_data
);

    logic [`OOO_REG_NUM-1:0][`OOO_DATA_W-1:0] rf_data;
    logic [`OOO_REG_NUM-1:0]                  rf_busy;
    logic                                     mark_valid;
    logic [`OOO_TAG_W-1:0]                    mark_tag;
    logic                                     dec_valid;
    iq_entry_t                                dec_entry;
    logic                                     iq_full;
    logic                                     iss_valid;
    iq_entry_t                                iss_entry;

    dispatch_decode decode_i (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rf_data     (rf_data),
        .rf_busy     (rf_busy),
        .iq_full     (iq_full),
        .res_valid   (res_valid),
        .res_tag     (res_tag),
        .res_data    (res_data),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .dec_entry   (dec_entry),
        .mark_valid  (mark_valid),
        .mark_tag    (mark_tag)
    );

    issue_queue queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_entry (dec_entry),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_data  (res_data),
        .iq_full   (iq_full),
        .iss_valid (iss_valid),
        .iss_entry (iss_entry)
    );

    alu_execute alu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss_entry (iss_entry),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_data  (res_data)
    );

    result_regfile regfile_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .res_valid  (res_valid),
        .res_tag    (res_tag),
        .res_data   (res_data),
        .mark_valid (mark_valid),
        .mark_tag   (mark_tag),
        .rf_data    (rf_data),
        .rf_busy    (rf_busy)
    );

endmodule

//--- source/result_regfile.sv
`timescale 1ns/1ns

`include "ooo_macros.svh"

module result_regfile (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      res_valid,
    input  logic [`OOO_TAG_W-1:0]                     res_tag,
    input  logic [`OOO_DATA_W-1:0]                    res_data,
    input  logic                                      mark_valid,
    input  logic [`OOO_TAG_W-1:0]                     mark_tag,
    output logic [`OOO_REG_NUM-1:0][`OOO_DATA_W-1:0]  rf_data,
    output logic [`OOO_REG_NUM-1:0]                   rf_busy
);

    logic [`OOO_REG_NUM-1:0][`OOO_DATA_W-1:0] regs_q;
    logic [`OOO_REG_NUM-1:0]                  busy_q;
    logic [`OOO_REG_NUM-1:0]                  busy_next;

    // registers start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else if (res_valid) begin
            regs_q[res_tag] <= res_data;
        end
    end

    always_comb begin
        busy_next = busy_q;
        if (res_valid) begin
            busy_next[res_tag] = 1'b0;
        end
        // new writer beats the retiring one
        if (mark_valid) begin
            busy_next[mark_tag] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_next;
        end
    end

    assign rf_data = regs_q;
    assign rf_busy = busy_q;

endmodule

//--- source/alu_execute.sv
`timescale 1ns/1ns

`include "ooo_macros.svh"

module alu_execute
    import ooo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   iss_valid,
    input  iq_entry_t              iss_entry,
    output logic                   res_valid,
    output logic [`OOO_TAG_W-1:0]  res_tag,
    output logic [`OOO_DATA_W-1:0] res_data
);

    logic [`OOO_DATA_W-1:0]  opa;
    logic [`OOO_DATA_W-1:0]  opb;
    logic [`OOO_SHAMT_W-1:0] shamt;
    logic [`OOO_DATA_W-1:0]  result;

    assign opa   = iss_entry.src1.data;
    assign opb   = iss_entry.src2.data;
    assign shamt = opb[`OOO_SHAMT_W-1:0];

    always_comb begin
        case (iss_entry.op)
            OP_ADD:  result = opa + opb;
            OP_SUB:  result = opa - opb;
            OP_AND:  result = opa & opb;
            OP_OR:   result = opa | opb;
            OP_XOR:  result = opa ^ opb;
            OP_SLL:  result = opa << shamt;
            OP_SRL:  result = opa >> shamt;
            // immediate already zero-extended by decode
            OP_LI:   result = opa;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            res_tag  <= iss_entry.dst;
            res_data <= result;
        end
    end

endmodule

//--- source/issue_queue.sv
`timescale 1ns/1ns

`include "ooo_macros.svh"

module issue_queue
    import ooo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dec_valid,
    input  iq_entry_t              dec_entry,
    input  logic                   res_valid,
    input  logic [`OOO_TAG_W-1:0]  res_tag,
    input  logic [`OOO_DATA_W-1:0] res_data,
    output logic                   iq_full,
    output logic                   iss_valid,
    output iq_entry_t              iss_entry
);

    // entry 0 is the oldest, tail points at the first free slot
    iq_entry_t              queue_q    [`OOO_QUEUE_LEN];
    iq_entry_t              queue_wake [`OOO_QUEUE_LEN];
    iq_entry_t              queue_next [`OOO_QUEUE_LEN];
    iq_entry_t              in_wake;
    logic [`OOO_PTR_W-1:0]  tail_q;
    logic [`OOO_PTR_W-1:0]  tail_after_iss;
    logic [`OOO_PTR_W-1:0]  tail_next;
    logic                   sel_found;
    logic [`OOO_PTR_W-1:0]  sel_idx;

    function automatic src_opnd_t wake_src(input src_opnd_t s);
        src_opnd_t w;
        w = s;
        if (!s.ready && res_valid && s.tag == res_tag) begin
            w.ready = 1'b1;
            w.data  = res_data;
        end
        return w;
    endfunction

    // wakeup of stored entries and the incoming one
    always_comb begin
        for (int j = 0; j < `OOO_QUEUE_LEN; j++) begin
            queue_wake[j]      = queue_q[j];
            queue_wake[j].src1 = wake_src(queue_q[j].src1);
            queue_wake[j].src2 = wake_src(queue_q[j].src2);
        end
        in_wake      = dec_entry;
        in_wake.src1 = wake_src(dec_entry.src1);
        in_wake.src2 = wake_src(dec_entry.src2);
    end

    // oldest ready entry wins
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int j = 0; j < `OOO_QUEUE_LEN; j++) begin
            if (!sel_found && j < tail_q &&
                queue_wake[j].src1.ready && queue_wake[j].src2.ready) begin
                sel_found = 1'b1;
                sel_idx   = `OOO_PTR_W'(j);
            end
        end
    end

    assign iss_valid = sel_found;
    assign iss_entry = queue_wake[sel_idx];

    // compact over the issued slot, then append
    always_comb begin
        for (int j = 0; j < `OOO_QUEUE_LEN; j++) begin
            queue_next[j] = queue_wake[j];
        end
        tail_after_iss = tail_q;

        if (sel_found) begin
            for (int j = 0; j < `OOO_QUEUE_LEN - 1; j++) begin
                if (j >= sel_idx) begin
                    queue_next[j] = queue_wake[j+1];
                end
            end
            tail_after_iss = tail_q - 1'b1;
        end

        // last slot kept free
        iq_full   = (tail_after_iss == '1);
        tail_next = tail_after_iss;

        if (dec_valid && !iq_full) begin
            queue_next[tail_after_iss] = in_wake;
            tail_next                  = tail_after_iss + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_q <= '0;
        end else begin
            tail_q <= tail_next;
        end
    end

    // slots at or past the tail are don't care
    always_ff @(posedge clk) begin
        for (int j = 0; j < `OOO_QUEUE_LEN; j++) begin
            queue_q[j] <= queue_next[j];
        end
    end

endmodule

//--- source/dispatch_decode.sv
`timescale 1ns/1ns

`include "ooo_macros.svh"

module dispatch_decode
    import ooo_pkg::*;
(
    input  logic                                      instr_valid,
    input  logic [`OOO_INSTR_W-1:0]                   instr,
    input  logic [`OOO_REG_NUM-1:0][`OOO_DATA_W-1:0]  rf_data,
    input  logic [`OOO_REG_NUM-1:0]                   rf_busy,
    input  logic                                      iq_full,
    input  logic                                      res_valid,
    input  logic [`OOO_TAG_W-1:0]                     res_tag,
    input  logic [`OOO_DATA_W-1:0]                    res_data,
    output logic                                      stall,
    output logic                                      dec_valid,
    output iq_entry_t                                 dec_entry,
    output logic                                      mark_valid,
    output logic [`OOO_TAG_W-1:0]                     mark_tag
);

    alu_op_e               op;
    logic [`OOO_TAG_W-1:0] dst;
    logic [`OOO_TAG_W-1:0] src1_reg;
    logic [`OOO_TAG_W-1:0] src2_reg;
    logic [`OOO_IMM_W-1:0] imm;
    logic                  dst_hazard;

    // register value, or the broadcast when the writer finishes now
    function automatic src_opnd_t read_src(input logic [`OOO_TAG_W-1:0] reg_id);
        src_opnd_t s;
        s.ready = 1'b1;
        s.tag   = reg_id;
        s.data  = rf_data[reg_id];
        if (rf_busy[reg_id]) begin
            if (res_valid && res_tag == reg_id) begin
                s.data = res_data;
            end else begin
                s.ready = 1'b0;
                s.data  = '0;
            end
        end
        return s;
    endfunction

    assign op       = alu_op_e'(instr[`OOO_OP_MSB:`OOO_OP_LSB]);
    assign dst      = instr[`OOO_DST_MSB:`OOO_DST_LSB];
    assign src1_reg = instr[`OOO_SRC1_MSB:`OOO_SRC1_LSB];
    assign src2_reg = instr[`OOO_SRC2_MSB:`OOO_SRC2_LSB];
    assign imm      = instr[`OOO_IMM_MSB:`OOO_IMM_LSB];

    // waw, unless the old writer retires this cycle
    assign dst_hazard = rf_busy[dst] && !(res_valid && res_tag == dst);

    assign stall     = instr_valid && (iq_full || dst_hazard);
    assign dec_valid = instr_valid && !stall;

    always_comb begin
        dec_entry.op  = op;
        dec_entry.dst = dst;
        if (op == OP_LI) begin
            dec_entry.src1.ready = 1'b1;
            dec_entry.src1.tag   = '0;
            dec_entry.src1.data  = {{(`OOO_DATA_W-`OOO_IMM_W){1'b0}}, imm};
            dec_entry.src2.ready = 1'b1;
            dec_entry.src2.tag   = '0;
            dec_entry.src2.data  = '0;
        end else begin
            dec_entry.src1 = read_src(src1_reg);
            dec_entry.src2 = read_src(src2_reg);
        end
    end

    assign mark_valid = dec_valid;
    assign mark_tag   = dst;

endmodule

//--- source/ooo_pkg.sv
package ooo_pkg;

    `include "ooo_macros.svh"

    // alu opcodes, top three bits of the word
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_LI  = 3'd7
    } alu_op_e;

    // tag is the architectural register number
    typedef struct packed {
        logic                  ready;
        logic [`OOO_TAG_W-1:0]  tag;
        logic [`OOO_DATA_W-1:0] data;
    } src_opnd_t;

    typedef struct packed {
        alu_op_e               op;
        logic [`OOO_TAG_W-1:0] dst;
        src_opnd_t             src1;
        src_opnd_t             src2;
    } iq_entry_t;

endpackage

//--- source/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// datapath sizes
`define OOO_DATA_W     16
`define OOO_REG_NUM    8
`define OOO_TAG_W      3

// one slot stays free, so 7 entries at most
`define OOO_QUEUE_LEN  8
`define OOO_PTR_W      3

`define OOO_IMM_W      6
`define OOO_SHAMT_W    4
`define OOO_INSTR_W    16

// instruction word fields
`define OOO_OP_MSB     15
`define OOO_OP_LSB     13
`define OOO_DST_MSB    12
`define OOO_DST_LSB    10
`define OOO_SRC1_MSB   9
`define OOO_SRC1_LSB   7
`define OOO_SRC2_MSB   6
`define OOO_SRC2_LSB   4
`define OOO_IMM_MSB    9
`define OOO_IMM_LSB    4

`endif
